/* verilog/decode_pkg.sv */
package decode_pkg;

    // Wishbone classic, master to slave
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] adr;
        logic [3:0]  sel;
    } wb_m2s_t;

    // Wishbone classic, slave to master
    typedef struct packed {
        logic [31:0] dat;
        logic        ack;
        logic        err;
    } wb_s2m_t;

    // High bit first, same order as the dispatch excp_num field
    typedef struct packed {
        logic ipe;
        logic ine;
        logic brk;
        logic sys;
        logic fetch_err;
        logic intr;
    } excp_vec_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] instr;
        logic        is_last_in_block;
        logic        fetch_err;
    } instr_buf_t;

    typedef enum logic [3:0] {
        OP_NOP = 4'd0,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_SLT,
        OP_LU12I,
        OP_CSRRD,
        OP_B,
        OP_BL,
        OP_SYSCALL,
        OP_BREAK
    } alu_op_e;

    // All zero when the sub-decoder misses, so results can be ORed
    typedef struct packed {
        logic        hit;
        alu_op_e     op;
        logic [1:0]  reg_read_valid;
        logic [9:0]  reg_read_addr;
        logic        reg_write_valid;
        logic [4:0]  reg_write_addr;
        logic        use_imm;
        logic [31:0] imm;
        logic        kernel;
        logic        brk;
        logic        sys;
    } sub_dec_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
        logic        is_last_in_block;
        excp_vec_t   excp_num;
        logic        excp;
        alu_op_e     op;
        logic [1:0]  reg_read_valid;
        logic [9:0]  reg_read_addr;
        logic        reg_write_valid;
        logic [4:0]  reg_write_addr;
        logic        use_imm;
        logic [31:0] imm;
    } dispatch_t;

    // 3R and trap encodings
    localparam logic [31:0] R3_MASK       = 32'hFFFF_8000;
    localparam logic [31:0] ADD_W_MATCH   = 32'h0010_0000;
    localparam logic [31:0] SUB_W_MATCH   = 32'h0011_0000;
    localparam logic [31:0] SLT_MATCH     = 32'h0012_0000;
    localparam logic [31:0] AND_MATCH     = 32'h0014_8000;
    localparam logic [31:0] OR_MATCH      = 32'h0015_0000;
    localparam logic [31:0] BREAK_MATCH   = 32'h002A_0000;
    localparam logic [31:0] SYSCALL_MATCH = 32'h002B_0000;

    // Immediate formats
    localparam logic [31:0] RI12_MASK     = 32'hFFC0_0000;
    localparam logic [31:0] ADDI_W_MATCH  = 32'h0280_0000;
    localparam logic [31:0] ANDI_MATCH    = 32'h0340_0000;
    localparam logic [31:0] CSRRD_MASK    = 32'hFF00_03E0;
    localparam logic [31:0] CSRRD_MATCH   = 32'h0400_0000;
    localparam logic [31:0] LU12I_MASK    = 32'hFE00_0000;
    localparam logic [31:0] LU12I_MATCH   = 32'h1400_0000;
    localparam logic [31:0] I26_MASK      = 32'hFC00_0000;
    localparam logic [31:0] B_MATCH       = 32'h5000_0000;
    localparam logic [31:0] BL_MATCH      = 32'h5400_0000;

endpackage

/* verilog/pc_counter.sv */
`timescale 1ns/1ps

module pc_counter #(
    parameter int COUNT_W = 8
) (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               load_i,
    input  logic [31:0]        start_pc_i,
    input  logic [COUNT_W-1:0] count_i,
    input  logic               advance_i,
    output logic [31:0]        pc_o,
    output logic               last_o
);

    logic [COUNT_W-1:0] count_q;
    logic [31:0]        pc_q;

    // Instructions still to be fetched, current one included
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            count_q <= '0;
        end else if (load_i) begin
            count_q <= count_i;
        end else if (advance_i) begin
            count_q <= count_q - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load_i) begin
            pc_q <= start_pc_i;
        end else if (advance_i) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    assign pc_o   = pc_q;
    assign last_o = (count_q == COUNT_W'(1));

    // Sequencer must stop after the last instruction of a run
    a_no_advance_past_end: assert property (
        @(posedge clk) disable iff (!arst_n_i) advance_i |-> (count_q != '0)
    );

endmodule

/* verilog/fetch_fsm.sv */
`timescale 1ns/1ps

module fetch_fsm (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  logic                   start_i,
    input  logic [31:0]            pc_i,
    input  logic                   last_i,
    output decode_pkg::wb_m2s_t    wb_o,
    input  decode_pkg::wb_s2m_t    wb_i,
    input  logic                   dispatch_ready_i,
    output logic                   load_o,
    output logic                   advance_o,
    output decode_pkg::instr_buf_t buf_o,
    output logic                   busy_o
);

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        HOLD
    } state_e;

    state_e      state_q;
    state_e      state_d;
    logic        bus_done;
    logic        xfer;
    logic [31:0] buf_pc_q;
    logic [31:0] buf_instr_q;
    logic        buf_last_q;
    logic        buf_err_q;

    assign bus_done  = (state_q == REQ) && (wb_i.ack || wb_i.err);
    assign xfer      = (state_q == HOLD) && dispatch_ready_i;
    assign load_o    = (state_q == IDLE) && start_i;
    assign advance_o = xfer;
    assign busy_o    = (state_q != IDLE);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (start_i) begin
                    state_d = REQ;
                end
            end
            REQ: begin
                if (bus_done) begin
                    state_d = HOLD;
                end
            end
            HOLD: begin
                // Stop after the last word, else fetch the next one right away
                if (xfer) begin
                    state_d = buf_last_q ? IDLE : REQ;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Single read, held until ack or err
    always_comb begin
        wb_o     = '0;
        wb_o.cyc = (state_q == REQ);
        wb_o.stb = (state_q == REQ);
        wb_o.we  = 1'b0;
        wb_o.adr = pc_i;
        wb_o.sel = 4'hF;
    end

    // Error response loads word zero and flags the fetch
    always_ff @(posedge clk) begin
        if (bus_done) begin
            buf_pc_q    <= pc_i;
            buf_instr_q <= wb_i.err ? 32'h0 : wb_i.dat;
            buf_last_q  <= last_i;
            buf_err_q   <= wb_i.err;
        end
    end

    assign buf_o.valid            = (state_q == HOLD);
    assign buf_o.pc               = buf_pc_q;
    assign buf_o.instr            = buf_instr_q;
    assign buf_o.is_last_in_block = buf_last_q;
    assign buf_o.fetch_err        = buf_err_q;

    a_stb_with_cyc: assert property (
        @(posedge clk) disable iff (!arst_n_i) wb_o.stb |-> wb_o.cyc
    );

    // Request holds until the slave answers
    a_req_held: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        wb_o.stb && !(wb_i.ack || wb_i.err) |=> wb_o.stb && $stable(wb_o.adr)
    );

    a_buf_stable: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        buf_o.valid && !dispatch_ready_i |=> $stable(buf_o)
    );

endmodule

/* verilog/decoder_reg_fmt.sv */
`timescale 1ns/1ps

module decoder_reg_fmt (
    input  logic [31:0]          instr_i,
    output decode_pkg::sub_dec_t result_o
);

    logic [4:0]          rd;
    logic [4:0]          rj;
    logic [4:0]          rk;
    logic [31:0]         masked;
    logic                is_3r;
    decode_pkg::alu_op_e op;

    assign rd     = instr_i[4:0];
    assign rj     = instr_i[9:5];
    assign rk     = instr_i[14:10];
    assign masked = instr_i & decode_pkg::R3_MASK;

    // All members share one mask, the opcode comes from the pattern
    always_comb begin
        is_3r = 1'b1;
        op    = decode_pkg::OP_NOP;
        case (masked)
            decode_pkg::ADD_W_MATCH: op = decode_pkg::OP_ADD;
            decode_pkg::SUB_W_MATCH: op = decode_pkg::OP_SUB;
            decode_pkg::AND_MATCH:   op = decode_pkg::OP_AND;
            decode_pkg::OR_MATCH:    op = decode_pkg::OP_OR;
            decode_pkg::SLT_MATCH:   op = decode_pkg::OP_SLT;
            default: begin
                is_3r = 1'b0;
            end
        endcase
    end

    always_comb begin
        result_o = '0;
        if (is_3r) begin
            result_o.hit             = 1'b1;
            result_o.op              = op;
            result_o.reg_read_valid  = 2'b11;
            result_o.reg_read_addr   = {rk, rj};
            result_o.reg_write_valid = 1'b1;
            result_o.reg_write_addr  = rd;
        end else if (masked == decode_pkg::SYSCALL_MATCH) begin
            // Code field stays in instr for the handler
            result_o.hit = 1'b1;
            result_o.op  = decode_pkg::OP_SYSCALL;
            result_o.sys = 1'b1;
        end else if (masked == decode_pkg::BREAK_MATCH) begin
            result_o.hit = 1'b1;
            result_o.op  = decode_pkg::OP_BREAK;
            result_o.brk = 1'b1;
        end
    end

endmodule

/* verilog/decoder_imm_fmt.sv */
`timescale 1ns/1ps

module decoder_imm_fmt (
    input  logic [31:0]          instr_i,
    output decode_pkg::sub_dec_t result_o
);

    logic [4:0]  rd;
    logic [4:0]  rj;
    logic [31:0] si12_ext;
    logic [31:0] ui12_ext;
    logic [31:0] csr_num;
    logic [31:0] si20_shl;
    logic [31:0] offs26_ext;

    assign rd = instr_i[4:0];
    assign rj = instr_i[9:5];

    // Immediate extensions
    assign si12_ext   = {{20{instr_i[21]}}, instr_i[21:10]};
    assign ui12_ext   = {20'h0, instr_i[21:10]};
    assign csr_num    = {18'h0, instr_i[23:10]};
    assign si20_shl   = {instr_i[24:5], 12'h0};
    // offs26 is split, high part sits in bits 9:0
    assign offs26_ext = {{4{instr_i[9]}}, instr_i[9:0], instr_i[25:10], 2'b00};

    always_comb begin
        result_o = '0;
        if ((instr_i & decode_pkg::RI12_MASK) == decode_pkg::ADDI_W_MATCH) begin
            result_o.hit             = 1'b1;
            result_o.op              = decode_pkg::OP_ADD;
            result_o.reg_read_valid  = 2'b01;
            result_o.reg_read_addr   = {5'd0, rj};
            result_o.reg_write_valid = 1'b1;
            result_o.reg_write_addr  = rd;
            result_o.use_imm         = 1'b1;
            result_o.imm             = si12_ext;
        end else if ((instr_i & decode_pkg::RI12_MASK) == decode_pkg::ANDI_MATCH) begin
            result_o.hit             = 1'b1;
            result_o.op              = decode_pkg::OP_AND;
            result_o.reg_read_valid  = 2'b01;
            result_o.reg_read_addr   = {5'd0, rj};
            result_o.reg_write_valid = 1'b1;
            result_o.reg_write_addr  = rd;
            result_o.use_imm         = 1'b1;
            result_o.imm             = ui12_ext;
        end else if ((instr_i & decode_pkg::CSRRD_MASK) == decode_pkg::CSRRD_MATCH) begin
            // Privileged, the CSR number rides in imm
            result_o.hit             = 1'b1;
            result_o.op              = decode_pkg::OP_CSRRD;
            result_o.reg_write_valid = 1'b1;
            result_o.reg_write_addr  = rd;
            result_o.use_imm         = 1'b1;
            result_o.imm             = csr_num;
            result_o.kernel          = 1'b1;
        end else if ((instr_i & decode_pkg::LU12I_MASK) == decode_pkg::LU12I_MATCH) begin
            result_o.hit             = 1'b1;
            result_o.op              = decode_pkg::OP_LU12I;
            result_o.reg_write_valid = 1'b1;
            result_o.reg_write_addr  = rd;
            result_o.use_imm         = 1'b1;
            result_o.imm             = si20_shl;
        end else if ((instr_i & decode_pkg::I26_MASK) == decode_pkg::B_MATCH) begin
            result_o.hit     = 1'b1;
            result_o.op      = decode_pkg::OP_B;
            result_o.use_imm = 1'b1;
            result_o.imm     = offs26_ext;
        end else if ((instr_i & decode_pkg::I26_MASK) == decode_pkg::BL_MATCH) begin
            // Link register is r1
            result_o.hit             = 1'b1;
            result_o.op              = decode_pkg::OP_BL;
            result_o.reg_write_valid = 1'b1;
            result_o.reg_write_addr  = 5'd1;
            result_o.use_imm         = 1'b1;
            result_o.imm             = offs26_ext;
        end
    end

endmodule

/* verilog/id.sv */
`timescale 1ns/1ps

module id (
    input  decode_pkg::instr_buf_t buf_i,
    input  logic                   has_int_i,
    input  logic [1:0]             csr_plv_i,
    output decode_pkg::dispatch_t  dispatch_o
);

    logic [31:0]           instr;
    logic                  excp_nop;
    decode_pkg::sub_dec_t  reg_res;
    decode_pkg::sub_dec_t  imm_res;
    decode_pkg::sub_dec_t  dec;
    decode_pkg::excp_vec_t excp_num;

    // Empty buffer decodes as word zero, which matches nothing
    assign instr = buf_i.valid ? buf_i.instr : 32'h0;

    decoder_reg_fmt u_decoder_reg_fmt (
        .instr_i  (instr),
        .result_o (reg_res)
    );

    decoder_imm_fmt u_decoder_imm_fmt (
        .instr_i  (instr),
        .result_o (imm_res)
    );

    // At most one sub-decoder hits, a miss is all zeros
    assign dec = decode_pkg::sub_dec_t'(reg_res | imm_res);

    assign excp_num.ipe       = dec.kernel && (csr_plv_i == 2'b11);
    // A failed fetch has no real word to call illegal
    assign excp_num.ine       = buf_i.valid && !dec.hit && !buf_i.fetch_err;
    assign excp_num.brk       = dec.brk;
    assign excp_num.sys       = dec.sys;
    assign excp_num.fetch_err = buf_i.valid && buf_i.fetch_err;
    assign excp_num.intr      = buf_i.valid && has_int_i;

    // Faulting instruction still dispatches, but as a NOP
    assign excp_nop = excp_num.ipe | excp_num.ine | excp_num.fetch_err;

    assign dispatch_o.pc               = buf_i.valid ? buf_i.pc : 32'h0;
    assign dispatch_o.instr            = instr;
    assign dispatch_o.is_last_in_block = buf_i.valid && buf_i.is_last_in_block;
    assign dispatch_o.excp_num         = excp_num;
    assign dispatch_o.excp             = |excp_num;

    assign dispatch_o.op              = excp_nop ? decode_pkg::OP_NOP : dec.op;
    assign dispatch_o.reg_read_valid  = excp_nop ? 2'b00 : dec.reg_read_valid;
    assign dispatch_o.reg_read_addr   = excp_nop ? 10'h0 : dec.reg_read_addr;
    assign dispatch_o.reg_write_valid = excp_nop ? 1'b0 : dec.reg_write_valid;
    assign dispatch_o.reg_write_addr  = excp_nop ? 5'h0 : dec.reg_write_addr;
    assign dispatch_o.use_imm         = excp_nop ? 1'b0 : dec.use_imm;
    assign dispatch_o.imm             = excp_nop ? 32'h0 : dec.imm;

    // Encodings of the two formats must not overlap
    a_single_hit: assert final (!(reg_res.hit && imm_res.hit))
        else $error("both sub-decoders hit on %h", instr);

endmodule

/* verilog/decode_top.sv */
`timescale 1ns/1ps

module decode_top #(
    parameter int COUNT_W = 8
) (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  start_i,
    input  logic [31:0]           start_pc_i,
    input  logic [COUNT_W-1:0]    count_i,
    output decode_pkg::wb_m2s_t   wb_o,
    input  decode_pkg::wb_s2m_t   wb_i,
    input  logic                  has_int_i,
    input  logic [1:0]            csr_plv_i,
    input  logic                  dispatch_ready_i,
    output logic                  dispatch_valid_o,
    output decode_pkg::dispatch_t dispatch_o,
    output logic                  busy_o
);

    logic                   load;
    logic                   advance;
    logic                   last;
    logic [31:0]            pc;
    decode_pkg::instr_buf_t ibuf;

    pc_counter #(
        .COUNT_W (COUNT_W)
    ) u_pc_counter (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .load_i     (load),
        .start_pc_i (start_pc_i),
        .count_i    (count_i),
        .advance_i  (advance),
        .pc_o       (pc),
        .last_o     (last)
    );

    fetch_fsm u_fetch_fsm (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .start_i          (start_i),
        .pc_i             (pc),
        .last_i           (last),
        .wb_o             (wb_o),
        .wb_i             (wb_i),
        .dispatch_ready_i (dispatch_ready_i),
        .load_o           (load),
        .advance_o        (advance),
        .buf_o            (ibuf),
        .busy_o           (busy_o)
    );

    id u_id (
        .buf_i      (ibuf),
        .has_int_i  (has_int_i),
        .csr_plv_i  (csr_plv_i),
        .dispatch_o (dispatch_o)
    );

    assign dispatch_valid_o = ibuf.valid;

endmodule

/* testbench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 10
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Reset released on a rising edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

/* testbench/tb_checker.sv */
`timescale 1ns/1ps

module tb_checker #(
    parameter int N_ENTRIES = 16
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  decode_pkg::wb_m2s_t   wb_m2s_i,
    input  logic                  dispatch_valid_i,
    input  logic                  dispatch_ready_i,
    input  decode_pkg::dispatch_t dispatch_i,
    input  logic                  busy_i,
    input  decode_pkg::dispatch_t exp_i,
    output logic                  done_o,
    output int                    pass_cnt_o,
    output int                    fail_cnt_o,
    output int                    err_cnt_o
);

    int   seen       = 0;
    int   pass_cnt   = 0;
    int   fail_cnt   = 0;
    int   err_cnt    = 0;
    int   entry_errs = 0;
    logic busy_check = 1'b0;
    logic done_q     = 1'b0;

    assign done_o     = done_q;
    assign pass_cnt_o = pass_cnt;
    assign fail_cnt_o = fail_cnt;
    assign err_cnt_o  = err_cnt;

    task automatic check_field(
        input string       name,
        input logic [31:0] got,
        input logic [31:0] want
    );
        if (got !== want) begin
            $display("ERROR %0t: entry %0d field %s is %h, expected %h",
                     $time, seen, name, got, want);
            entry_errs++;
            err_cnt++;
        end
    endtask

    // Values are sampled at the edge where the transfer happens
    always @(posedge clk_i) begin
        if (rst_n_i) begin
            // Fetch is a plain read of a full word
            if (wb_m2s_i.stb === 1'b1 && (wb_m2s_i.cyc !== 1'b1 || wb_m2s_i.we !== 1'b0 ||
                                          wb_m2s_i.sel !== 4'hF)) begin
                $display("ERROR %0t: bus request with cyc %b we %b sel %h, expected 1 0 f",
                         $time, wb_m2s_i.cyc, wb_m2s_i.we, wb_m2s_i.sel);
                err_cnt++;
            end
            // One cycle after the last transfer the sequencer is idle
            if (busy_check) begin
                busy_check = 1'b0;
                if (busy_i !== 1'b0) begin
                    $display("ERROR %0t: busy_o still high after the final transfer", $time);
                    err_cnt++;
                end
                done_q <= 1'b1;
            end
            if (dispatch_valid_i && dispatch_ready_i) begin
                if (seen >= N_ENTRIES) begin
                    $display("ERROR %0t: dispatch transfer after the end of the run", $time);
                    err_cnt++;
                end else begin
                    entry_errs = 0;
                    check_field("pc", dispatch_i.pc, exp_i.pc);
                    check_field("instr", dispatch_i.instr, exp_i.instr);
                    check_field("is_last_in_block", dispatch_i.is_last_in_block,
                                exp_i.is_last_in_block);
                    check_field("excp_num", dispatch_i.excp_num, exp_i.excp_num);
                    check_field("excp", dispatch_i.excp, exp_i.excp);
                    check_field("op", dispatch_i.op, exp_i.op);
                    check_field("reg_read_valid", dispatch_i.reg_read_valid,
                                exp_i.reg_read_valid);
                    check_field("reg_read_addr", dispatch_i.reg_read_addr, exp_i.reg_read_addr);
                    check_field("reg_write_valid", dispatch_i.reg_write_valid,
                                exp_i.reg_write_valid);
                    check_field("reg_write_addr", dispatch_i.reg_write_addr,
                                exp_i.reg_write_addr);
                    check_field("use_imm", dispatch_i.use_imm, exp_i.use_imm);
                    check_field("imm", dispatch_i.imm, exp_i.imm);
                    if (entry_errs == 0) begin
                        pass_cnt++;
                    end else begin
                        fail_cnt++;
                    end
                    $display("entry %2d pc %h op %0d excp %b: %s", seen, dispatch_i.pc,
                             dispatch_i.op, dispatch_i.excp_num,
                             (entry_errs == 0) ? "ok" : "mismatch");
                    if (seen == N_ENTRIES - 1) begin
                        busy_check = 1'b1;
                    end
                    seen++;
                end
            end
        end
    end

endmodule

/* testbench/tb_top.sv */
`timescale 1ns/1ps

module tb_top;

    localparam int          N_ENTRIES      = 16;
    localparam int          COUNT_W        = 8;
    localparam logic [31:0] START_PC       = 32'h1C00_0100;
    localparam int          TIMEOUT_CYCLES = N_ENTRIES * 12 + 40;

    typedef struct packed {
        logic [31:0]           instr;
        logic [1:0]            plv;
        logic                  has_int;
        logic                  bus_err;
        decode_pkg::alu_op_e   op;
        logic [1:0]            rd_valid;
        logic [9:0]            rd_addr;
        logic                  wr_valid;
        logic [4:0]            wr_addr;
        logic                  use_imm;
        logic [31:0]           imm;
        decode_pkg::excp_vec_t excp;
    } stim_t;

    logic                  clk;
    logic                  rst_n;
    logic                  start;
    logic                  has_int;
    logic [1:0]            csr_plv;
    logic                  ready = 1'b0;
    decode_pkg::wb_m2s_t   wb_m2s;
    decode_pkg::wb_s2m_t   wb_s2m = '0;
    logic                  dispatch_valid;
    decode_pkg::dispatch_t dispatch;
    logic                  busy;

    stim_t                 tbl [N_ENTRIES];
    decode_pkg::dispatch_t exp_pkt;
    logic [31:0]           rng        = 32'hC795;
    logic                  bus_active = 1'b0;
    logic [1:0]            wait_left  = 2'd0;
    logic [31:0]           offset;
    int                    cycles     = 0;
    logic                  chk_done;
    int                    pass_cnt;
    int                    fail_cnt;
    int                    err_cnt;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // A bus error delivers word zero, faults leave the decoded fields zero
    function automatic decode_pkg::dispatch_t expected_packet(input int idx);
        decode_pkg::dispatch_t p;
        stim_t                 s;
        s                  = tbl[idx];
        p.pc               = START_PC + 32'(idx) * 32'd4;
        p.instr            = s.bus_err ? 32'h0 : s.instr;
        p.is_last_in_block = (idx == N_ENTRIES - 1);
        p.excp_num         = s.excp;
        p.excp             = |s.excp;
        p.op               = s.op;
        p.reg_read_valid   = s.rd_valid;
        p.reg_read_addr    = s.rd_addr;
        p.reg_write_valid  = s.wr_valid;
        p.reg_write_addr   = s.wr_addr;
        p.use_imm          = s.use_imm;
        p.imm              = s.imm;
        return p;
    endfunction

    tb_clock #(
        .PERIOD_NS    (8),
        .RESET_CYCLES (10)
    ) u_clock (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    decode_top #(
        .COUNT_W (COUNT_W)
    ) DUT (
        .clk              (clk),
        .arst_n_i         (rst_n),
        .start_i          (start),
        .start_pc_i       (START_PC),
        .count_i          (COUNT_W'(N_ENTRIES)),
        .wb_o             (wb_m2s),
        .wb_i             (wb_s2m),
        .has_int_i        (has_int),
        .csr_plv_i        (csr_plv),
        .dispatch_ready_i (ready),
        .dispatch_valid_o (dispatch_valid),
        .dispatch_o       (dispatch),
        .busy_o           (busy)
    );

    tb_checker #(
        .N_ENTRIES (N_ENTRIES)
    ) u_checker (
        .clk_i            (clk),
        .rst_n_i          (rst_n),
        .wb_m2s_i         (wb_m2s),
        .dispatch_valid_i (dispatch_valid),
        .dispatch_ready_i (ready),
        .dispatch_i       (dispatch),
        .busy_i           (busy),
        .exp_i            (exp_pkt),
        .done_o           (chk_done),
        .pass_cnt_o       (pass_cnt),
        .fail_cnt_o       (fail_cnt),
        .err_cnt_o        (err_cnt)
    );

    assign offset = wb_m2s.adr - START_PC;

    // Wishbone slave with 0 to 3 wait cycles, ready low about one cycle in four
    always @(posedge clk) begin
        if (rst_n) begin
            rng = xorshift32(rng);
            ready <= (rng[3:2] != 2'b00);
            if (wb_s2m.ack || wb_s2m.err) begin
                wb_s2m     <= '0;
                bus_active <= 1'b0;
            end else if (wb_m2s.cyc && wb_m2s.stb) begin
                if (!bus_active) begin
                    bus_active <= 1'b1;
                    wait_left  <= rng[1:0];
                end else if (wait_left == 2'd0) begin
                    wb_s2m.dat <= tbl[offset[5:2]].instr;
                    wb_s2m.ack <= !tbl[offset[5:2]].bus_err;
                    wb_s2m.err <= tbl[offset[5:2]].bus_err;
                end else begin
                    wait_left <= wait_left - 2'd1;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (rst_n) begin
            cycles <= cycles + 1;
            if (cycles >= TIMEOUT_CYCLES) begin
                $display("Timeout: dispatch stalled after %0d of %0d entries",
                         pass_cnt + fail_cnt, N_ENTRIES);
                $display("** FAIL **");
                $finish;
            end
        end
    end

    initial begin
        start   = 1'b0;
        has_int = 1'b0;
        csr_plv = 2'd0;
        exp_pkt = '0;
        // instr, plv, has_int, bus_err, op, reads, read addr {rk/rd, rj}, write, waddr,
        // use_imm, imm, excp {ipe, ine, brk, sys, fetch_err, intr}
        tbl[0]  = '{32'h0010_0823, 2'd0, 1'b0, 1'b0, decode_pkg::OP_ADD,
                    2'b11, 10'h041, 1'b1, 5'd3, 1'b0, 32'h0, 6'b000000};
        tbl[1]  = '{32'h0011_18A4, 2'd0, 1'b0, 1'b0, decode_pkg::OP_SUB,
                    2'b11, 10'h0C5, 1'b1, 5'd4, 1'b0, 32'h0, 6'b000000};
        tbl[2]  = '{32'h0014_A507, 2'd0, 1'b0, 1'b0, decode_pkg::OP_AND,
                    2'b11, 10'h128, 1'b1, 5'd7, 1'b0, 32'h0, 6'b000000};
        // User instruction at plv 3 is not privileged
        tbl[3]  = '{32'h0015_316A, 2'd3, 1'b0, 1'b0, decode_pkg::OP_OR,
                    2'b11, 10'h18B, 1'b1, 5'd10, 1'b0, 32'h0, 6'b000000};
        tbl[4]  = '{32'h0012_3DCD, 2'd0, 1'b1, 1'b0, decode_pkg::OP_SLT,
                    2'b11, 10'h1EE, 1'b1, 5'd13, 1'b0, 32'h0, 6'b000001};
        // addi.w r2, r3, -4
        tbl[5]  = '{32'h02BF_F062, 2'd0, 1'b0, 1'b0, decode_pkg::OP_ADD,
                    2'b01, 10'h003, 1'b1, 5'd2, 1'b1, 32'hFFFF_FFFC, 6'b000000};
        // andi r4, r5, 0x800 stays positive
        tbl[6]  = '{32'h0360_00A4, 2'd0, 1'b0, 1'b0, decode_pkg::OP_AND,
                    2'b01, 10'h005, 1'b1, 5'd4, 1'b1, 32'h0000_0800, 6'b000000};
        tbl[7]  = '{32'h1500_0026, 2'd0, 1'b0, 1'b0, decode_pkg::OP_LU12I,
                    2'b00, 10'h000, 1'b1, 5'd6, 1'b1, 32'h8000_1000, 6'b000000};
        // b -8
        tbl[8]  = '{32'h53FF_FBFF, 2'd0, 1'b0, 1'b0, decode_pkg::OP_B,
                    2'b00, 10'h000, 1'b0, 5'd0, 1'b1, 32'hFFFF_FFF8, 6'b000000};
        tbl[9]  = '{32'h5400_4000, 2'd0, 1'b0, 1'b0, decode_pkg::OP_BL,
                    2'b00, 10'h000, 1'b1, 5'd1, 1'b1, 32'h0000_0040, 6'b000000};
        tbl[10] = '{32'h0400_1405, 2'd0, 1'b0, 1'b0, decode_pkg::OP_CSRRD,
                    2'b00, 10'h000, 1'b1, 5'd5, 1'b1, 32'h0000_0005, 6'b000000};
        // csrrd at plv 3 becomes a NOP
        tbl[11] = '{32'h0400_0406, 2'd3, 1'b0, 1'b0, decode_pkg::OP_NOP,
                    2'b00, 10'h000, 1'b0, 5'd0, 1'b0, 32'h0, 6'b100000};
        tbl[12] = '{32'h002B_0011, 2'd0, 1'b0, 1'b0, decode_pkg::OP_SYSCALL,
                    2'b00, 10'h000, 1'b0, 5'd0, 1'b0, 32'h0, 6'b000100};
        tbl[13] = '{32'h002A_0000, 2'd0, 1'b0, 1'b0, decode_pkg::OP_BREAK,
                    2'b00, 10'h000, 1'b0, 5'd0, 1'b0, 32'h0, 6'b001000};
        tbl[14] = '{32'hFFFF_FFFF, 2'd0, 1'b0, 1'b0, decode_pkg::OP_NOP,
                    2'b00, 10'h000, 1'b0, 5'd0, 1'b0, 32'h0, 6'b010000};
        tbl[15] = '{32'h0010_0823, 2'd0, 1'b0, 1'b1, decode_pkg::OP_NOP,
                    2'b00, 10'h000, 1'b0, 5'd0, 1'b0, 32'h0, 6'b000010};

        while (!rst_n) @(posedge clk);
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        // Side inputs follow the entry in the buffer, moved on at each transfer
        for (int i = 0; i < N_ENTRIES; i++) begin
            exp_pkt <= expected_packet(i);
            csr_plv <= tbl[i].plv;
            has_int <= tbl[i].has_int;
            @(posedge clk);
            while (!(dispatch_valid && ready)) @(posedge clk);
        end
        while (!chk_done) @(posedge clk);
        $display("Summary: %0d entries, %0d passed, %0d failed, %0d errors",
                 N_ENTRIES, pass_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0 && pass_cnt == N_ENTRIES) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* tb.f */
verilog/decode_pkg.sv
verilog/pc_counter.sv
verilog/fetch_fsm.sv
verilog/decoder_reg_fmt.sv
verilog/decoder_imm_fmt.sv
verilog/id.sv
verilog/decode_top.sv
testbench/tb_clock.sv
testbench/tb_checker.sv
testbench/tb_top.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f tb.f -o tb_sim
./obj_dir/tb_sim | tee sim.log

if grep -qx '\*\* PASS \*\*' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
